// File: scan2x_top.f
+incdir+verilog
verilog/scan2x_pkg.sv
verilog/line_buffer_ram.sv
verilog/scan2x_line_timing.sv
verilog/scan2x_regs.sv
verilog/scan2x_pixel_stage.sv
verilog/scan2x_top.sv
tb/scan2x_checker.sv
tb/tb_scan2x.sv

// File: run_sim.sh
#!/bin/sh
# builds the scan doubler testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f scan2x_top.f --top-module tb_scan2x -o sim_scan2x \
    && ./obj_dir/sim_scan2x > sim.log 2>&1 \
    || echo "build or run error"
[ -f sim.log ] && cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "run passed" \
    || { echo "run failed"; exit 1; }

// File: tb/tb_scan2x.sv
// testbench top with clock, reset, pixel enables, random video lines, AXI4-Lite master tasks and tests
`timescale 1ns/1ps
`include "scan2x_config.svh"

module tb_scan2x;
    import scan2x_pkg::*;

    localparam int BLANK_PIX  = 16;
    localparam int LINE_PIX   = 64;
    localparam int LINE_TOTAL = BLANK_PIX + LINE_PIX;
    localparam int HS_LIMIT   = 200;    // clocks per bus handshake
    localparam int LINE_WAIT  = 4000;   // clocks per output line

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        pxl_cen = 1'b0;
    logic        pxl2_cen = 1'b0;
    pixel_t      base_pxl = '0;
    logic        hs = 1'b0;
    pixel_t      x2_pxl;
    logic        x2_hs;
    logic        x2_de;
    logic        x2_cen;
    logic [3:0]  awaddr = '0;
    logic        awvalid = 1'b0;
    logic        awready;
    logic [31:0] wdata = '0;
    logic [3:0]  wstrb = '0;
    logic        wvalid = 1'b0;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready = 1'b0;
    logic [3:0]  araddr = '0;
    logic        arvalid = 1'b0;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready = 1'b0;

    logic        video_on = 1'b0;
    logic [2:0]  phase = '0;
    int          pos = 0;         // pixel position within the input line
    logic        check_en = 1'b0;
    logic        exp_blend = 1'b0;
    sl_mode_e    exp_mode = SL_PURE;
    int          errors;
    int          lines_done;
    int          lines_checked;
    int          tb_fails = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] rd;
    logic [1:0]  resp;

    scan2x_top uut (
        .clk(clk), .rst_n(rst_n),
        .pxl_cen(pxl_cen), .pxl2_cen(pxl2_cen), .base_pxl(base_pxl), .hs(hs),
        .x2_pxl(x2_pxl), .x2_hs(x2_hs), .x2_de(x2_de), .x2_cen(x2_cen),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    scan2x_checker u_chk (
        .clk(clk), .rst_n(rst_n),
        .pxl_cen(pxl_cen), .hs(hs), .base_pxl(base_pxl),
        .x2_pxl(x2_pxl), .x2_hs(x2_hs), .x2_de(x2_de), .x2_cen(x2_cen),
        .check_en(check_en), .exp_blend(exp_blend), .exp_mode(exp_mode),
        .errors(errors), .lines_done(lines_done), .lines_checked(lines_checked)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // pixel enables in step with pxl_cen every 8th clock and pxl2_cen every 4th
    always @(posedge clk) begin
        if (!rst_n) begin
            phase    <= '0;
            pxl_cen  <= 1'b0;
            pxl2_cen <= 1'b0;
        end else begin
            phase    <= phase + 1'b1;
            pxl_cen  <= phase == 3'd7;
            pxl2_cen <= phase[1:0] == 2'd3;
            if (phase == 3'd7 && video_on) begin
                hs       <= pos < BLANK_PIX;  // blanking leads each line
                base_pxl <= (pos < BLANK_PIX) ? '0 : pixel_t'($urandom_range(4095, 1));
                pos      <= (pos == LINE_TOTAL - 1) ? 0 : pos + 1;
            end
        end
    end

    task automatic note_timeout(input string what);
        $display("timeout while waiting for %s", what);
        tb_fails++;
    endtask

    task automatic send_aw(input logic [3:0] addr);
        int n;
        n = 0;
        awaddr  <= addr;
        awvalid <= 1'b1;
        @(posedge clk);
        while (!awready && n < HS_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!awready) begin
            note_timeout("awready");
        end
        awvalid <= 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data);
        int n;
        n = 0;
        wdata  <= data;
        wstrb  <= 4'hf;
        wvalid <= 1'b1;
        @(posedge clk);
        while (!wready && n < HS_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!wready) begin
            note_timeout("wready");
        end
        wvalid <= 1'b0;
    endtask

    // order 0 sends both together while 1 sends the address first and 2 the data first
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int order,
                             output logic [1:0] wresp);
        int n;
        if (order == 1) begin
            send_aw(addr);
            send_w(data);
        end else if (order == 2) begin
            send_w(data);
            send_aw(addr);
        end else begin
            fork
                send_aw(addr);
                send_w(data);
            join
        end
        n = 0;
        bready <= 1'b1;
        @(posedge clk);
        while (!bvalid && n < HS_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!bvalid) begin
            note_timeout("bvalid");
        end
        wresp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] rd_resp);
        int n;
        n = 0;
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready && n < HS_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!arready) begin
            note_timeout("arready");
        end
        arvalid <= 1'b0;
        rready  <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!rvalid && n < HS_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!rvalid) begin
            note_timeout("rvalid");
        end
        data    = rdata;
        rd_resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic wait_lines(input int n);
        int target;
        int cnt;
        target = lines_done + n;
        cnt = 0;
        while (lines_done < target && cnt < n * LINE_WAIT) begin
            @(posedge clk);
            cnt++;
        end
        if (lines_done < target) begin
            note_timeout("output lines");
        end
    endtask

    // lines that straddle the register write are skipped
    task automatic set_config(input logic blend, input sl_mode_e mode);
        logic [1:0] wresp;
        check_en <= 1'b0;
        axi_write(`SCAN2X_REG_CTRL, {29'd0, blend, mode}, 0, wresp);
        u_chk.check_value("bresp", 32'h0, {30'd0, wresp});
        exp_blend <= blend;
        exp_mode  <= mode;
        wait_lines(2);
        check_en <= 1'b1;
    endtask

    task automatic check_lines(input int n);
        int mark;
        mark = lines_checked;
        wait_lines(n);
        if (lines_checked == mark) begin
            $display("no output line was compared");
            tb_fails++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = errors + tb_fails - err_mark;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errs);
        end
        err_mark = errors + tb_fails;
    endtask

    initial begin
        void'($urandom(32'h49e5));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // outputs are watched by the checker while no sync has come in
        repeat (50) @(posedge clk);
        axi_read(`SCAN2X_REG_CTRL, rd, resp);
        u_chk.check_value("rdata", 32'h0, rd);
        u_chk.check_value("rresp", 32'h0, {30'd0, resp});
        end_test("reset state");
        video_on <= 1'b1;

        set_config(1'b0, SL_PURE);
        check_lines(6);
        end_test("pure doubling");

        for (int m = 1; m < 4; m++) begin
            set_config(1'b0, sl_mode_e'(m));
            check_lines(4);
        end
        end_test("scanline dimming");

        for (int m = 0; m < 4; m++) begin
            set_config(1'b1, sl_mode_e'(m));
            check_lines(4);
        end
        end_test("neighbour blending");

        check_en <= 1'b0;
        axi_write(`SCAN2X_REG_CTRL, 32'h6, 1, resp);
        u_chk.check_value("bresp", 32'h0, {30'd0, resp});
        axi_read(`SCAN2X_REG_CTRL, rd, resp);
        u_chk.check_value("rdata", 32'h6, rd);
        axi_write(`SCAN2X_REG_CTRL, 32'h1, 2, resp);
        u_chk.check_value("bresp", 32'h0, {30'd0, resp});
        axi_read(`SCAN2X_REG_CTRL, rd, resp);
        u_chk.check_value("rdata", 32'h1, rd);
        axi_read(`SCAN2X_REG_LINELEN, rd, resp);
        u_chk.check_value("rdata", LINE_PIX, rd);
        axi_write(4'h8, 32'h7, 0, resp);  // unknown offset
        u_chk.check_value("bresp", 32'h2, {30'd0, resp});
        axi_read(`SCAN2X_REG_CTRL, rd, resp);
        u_chk.check_value("rdata", 32'h1, rd);
        axi_read(4'hc, rd, resp);
        u_chk.check_value("rresp", 32'h2, {30'd0, resp});
        end_test("AXI4-Lite access");

        $display("tests %0d, failed %0d, lines compared %0d, errors %0d, other failures %0d",
                 tests_run, tests_failed, lines_checked, errors, tb_fails);
        if (errors + tb_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/scan2x_checker.sv
// testbench checker: copies input lines, captures output lines, predicts doubling, blend and dimming
`timescale 1ns/1ps
`include "scan2x_config.svh"

module scan2x_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  hs,
    input  scan2x_pkg::pixel_t    base_pxl,
    input  scan2x_pkg::pixel_t    x2_pxl,
    input  logic                  x2_hs,
    input  logic                  x2_de,
    input  logic                  x2_cen,
    input  logic                  check_en,
    input  logic                  exp_blend,
    input  scan2x_pkg::sl_mode_e  exp_mode,
    output int                    errors,
    output int                    lines_done,
    output int                    lines_checked
);
    import scan2x_pkg::*;

    localparam int W          = `SCAN2X_COLORW;
    localparam int LINE_PIX   = 64;
    localparam int LINE_LIMIT = 4000;   // clocks allowed between two output lines

    pixel_t in_q[$];        // all active input pixels, line after line
    pixel_t out_line[$];    // output line being captured
    logic   seen_sync = 1'b0;
    int     quiet_clks = 0;
    int     line_errs = 0;
    int     value_errs = 0;

    assign errors = line_errs + value_errs;

    // expected output pixel i of an output line showing input line ln
    function automatic pixel_t expect_pixel(input int ln, input int i, input logic scan);
        pixel_t cur;
        pixel_t left;
        pixel_t res;
        int     ch;
        int     sh;
        cur  = in_q[ln*LINE_PIX + i];
        left = (i == 0) ? '0 : in_q[ln*LINE_PIX + i - 1];  // black before the first pixel
        sh   = 0;
        if (scan && exp_mode == SL_HALF) begin
            sh = 1;
        end else if (scan && exp_mode == SL_QUARTER) begin
            sh = 2;
        end
        for (int c = 0; c < 3; c++) begin
            ch = int'(cur[c*W +: W]);
            if (exp_blend) begin
                ch = (ch + int'(left[c*W +: W])) / 2;
            end
            ch = ch >> sh;  // averaging with black once or twice
            if (scan && exp_mode == SL_BLACK) begin
                ch = 0;
            end
            res[c*W +: W] = ch[W-1:0];
        end
        return res;
    endfunction

    // output lines come in pairs per input line, normal copy then scanline
    task automatic compare_line(input int idx);
        int     ln;
        logic   scan;
        pixel_t exp_px;
        ln   = idx / 2;
        scan = (idx % 2) == 1;
        if (out_line.size() != LINE_PIX) begin
            $display("[ERROR] x2_de pixel count, line %0d: expected 0x%0h, got 0x%0h",
                     idx, LINE_PIX, out_line.size());
            line_errs++;
        end else if (in_q.size() < (ln + 1) * LINE_PIX) begin
            $display("output line %0d came out before its input line was seen", idx);
            line_errs++;
        end else begin
            for (int i = 0; i < LINE_PIX; i++) begin
                exp_px = expect_pixel(ln, i, scan);
                if (out_line[i] !== exp_px) begin
                    $display("[ERROR] x2_pxl line %0d pixel %0d: expected 0x%03h, got 0x%03h",
                             idx, i, exp_px, out_line[i]);
                    line_errs++;
                end
            end
            lines_checked++;
        end
    endtask

    // single value compare, also used for the bus responses
    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        if (got_v !== exp_v) begin
            $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp_v, got_v);
            value_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            seen_sync     = 1'b0;
            quiet_clks    = 0;
            lines_done    <= 0;
            lines_checked = 0;
            out_line.delete();
        end else begin
            if (!seen_sync && (x2_hs || x2_de || x2_cen)) begin
                $display("[ERROR] x2_hs/x2_de/x2_cen before the first sync: expected 0x0, got 0x%0h",
                         {x2_hs, x2_de, x2_cen});
                line_errs++;
            end
            if (pxl_cen && hs) begin
                seen_sync = 1'b1;
            end
            if (pxl_cen && !hs && seen_sync) begin
                in_q.push_back(base_pxl);
            end
            if (x2_cen && x2_de) begin
                out_line.push_back(x2_pxl);
            end
            if (x2_cen && !x2_de && out_line.size() > 0) begin
                if (check_en) begin
                    compare_line(lines_done);
                end
                lines_done <= lines_done + 1;
                out_line.delete();
                quiet_clks = 0;
            end else if (seen_sync) begin
                quiet_clks++;
                if (quiet_clks == LINE_LIMIT) begin
                    $display("no output line finished within %0d clocks", LINE_LIMIT);
                    line_errs++;
                end
            end
        end
    end

endmodule

// File: verilog/scan2x_top.sv
// scan doubler top level: line timing, register block, line buffer and pixel stage
`timescale 1ns/1ps

module scan2x_top (
    input  logic                clk,
    input  logic                rst_n,
    // video in
    input  logic                pxl_cen,
    input  logic                pxl2_cen,
    input  scan2x_pkg::pixel_t  base_pxl,
    input  logic                hs,
    // video out
    output scan2x_pkg::pixel_t  x2_pxl,
    output logic                x2_hs,
    output logic                x2_de,
    output logic                x2_cen,
    // AXI4-Lite slave
    input  logic [3:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);
    import scan2x_pkg::*;

    logic        wr_en;
    logic        line_sel;
    line_addr_t  wr_addr;
    line_addr_t  rd_addr;
    line_addr_t  line_len;
    logic        rd_first;
    logic        rd_step;
    logic        scanline_on;
    logic        de_early;
    logic        hs_early;
    pixel_t      rd_data;
    sl_mode_e    sl_mode;
    logic        blend_en;

    scan2x_line_timing u_timing (
        .clk         (clk),
        .rst_n       (rst_n),
        .pxl_cen     (pxl_cen),
        .pxl2_cen    (pxl2_cen),
        .hs          (hs),
        .wr_en       (wr_en),
        .line_sel    (line_sel),
        .wr_addr     (wr_addr),
        .rd_addr     (rd_addr),
        .rd_first    (rd_first),
        .rd_step     (rd_step),
        .scanline_on (scanline_on),
        .de_early    (de_early),
        .hs_early    (hs_early),
        .line_len    (line_len)
    );

    scan2x_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .line_len (line_len),
        .sl_mode  (sl_mode),
        .blend_en (blend_en)
    );

    // write into the half that is not being read
    line_buffer_ram u_buffer (
        .clk     (clk),
        .we      (wr_en),
        .wr_addr ({~line_sel, wr_addr}),
        .wr_data (base_pxl),
        .rd_addr ({line_sel, rd_addr}),
        .rd_data (rd_data)
    );

    scan2x_pixel_stage u_pixel (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_data     (rd_data),
        .rd_first    (rd_first),
        .rd_step     (rd_step),
        .scanline_on (scanline_on),
        .de_early    (de_early),
        .hs_early    (hs_early),
        .sl_mode     (sl_mode),
        .blend_en    (blend_en),
        .x2_pxl      (x2_pxl),
        .x2_hs       (x2_hs),
        .x2_de       (x2_de),
        .x2_cen      (x2_cen)
    );

endmodule

// File: verilog/scan2x_pixel_stage.sv
// pixel stage: left-neighbour blending, scanline dimming, output registers
`timescale 1ns/1ps
`include "scan2x_config.svh"

module scan2x_pixel_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  scan2x_pkg::pixel_t    rd_data,
    input  logic                  rd_first,
    input  logic                  rd_step,
    input  logic                  scanline_on,
    input  logic                  de_early,
    input  logic                  hs_early,
    input  scan2x_pkg::sl_mode_e  sl_mode,
    input  logic                  blend_en,
    output scan2x_pkg::pixel_t    x2_pxl,
    output logic                  x2_hs,
    output logic                  x2_de,
    output logic                  x2_cen
);
    import scan2x_pkg::*;

    localparam int W = `SCAN2X_COLORW;

    // control aligned with rd_data (a) and with the blended pixel (b)
    logic    a_step, a_first, a_sl, a_de, a_hs;
    logic    b_step, b_sl, b_de, b_hs;
    pixel_t  prev_pxl;   // left neighbour
    pixel_t  b_pxl;
    pixel_t  dim_half;
    pixel_t  dim_pxl;

    function automatic chan_t chan_avg(input chan_t a, input chan_t b);
        logic [W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[W:1];  // floor average
    endfunction

    function automatic pixel_t pxl_avg(input pixel_t a, input pixel_t b);
        pixel_t res;
        for (int c = 0; c < 3; c++) begin
            res[c*W +: W] = chan_avg(a[c*W +: W], b[c*W +: W]);
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {a_step, a_first, a_sl, a_de, a_hs} <= '0;
            {b_step, b_sl, b_de, b_hs} <= '0;
            x2_cen <= 1'b0;
            x2_de  <= 1'b0;
            x2_hs  <= 1'b0;
        end else begin
            {a_step, a_first, a_sl, a_de, a_hs} <= {rd_step, rd_first, scanline_on,
                                                    de_early, hs_early};
            {b_step, b_sl, b_de, b_hs} <= {a_step, a_sl, a_de, a_hs};
            x2_cen <= b_step;
            x2_de  <= b_de;
            x2_hs  <= b_hs;
        end
    end

    always_ff @(posedge clk) begin
        if (a_step) begin
            prev_pxl <= rd_data;
            if (blend_en) begin
                b_pxl <= pxl_avg(rd_data, a_first ? '0 : prev_pxl);  // black before pixel 0
            end else begin
                b_pxl <= rd_data;
            end
        end
    end

    always_comb begin
        dim_half = pxl_avg(b_pxl, '0);
        case (sl_mode)
            SL_PURE:    dim_pxl = b_pxl;
            SL_HALF:    dim_pxl = dim_half;
            SL_QUARTER: dim_pxl = pxl_avg(dim_half, '0);
            default:    dim_pxl = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!b_de) begin
            x2_pxl <= '0;  // black in blanking
        end else if (b_sl) begin
            x2_pxl <= dim_pxl;
        end else begin
            x2_pxl <= b_pxl;
        end
    end

endmodule

// File: verilog/scan2x_regs.sv
// AXI4-Lite register block: scanline mode and blend control, measured line length
`timescale 1ns/1ps
`include "scan2x_config.svh"

module scan2x_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [3:0]              awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [3:0]              araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  scan2x_pkg::line_addr_t  line_len,
    output scan2x_pkg::sl_mode_e    sl_mode,
    output logic                    blend_en
);
    import scan2x_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,  // address held, waiting for data
        WR_DATA,  // data held, waiting for address
        WR_RESP
    } wr_state_e;

    wr_state_e   wr_state;
    logic [3:0]  aw_addr_q;
    logic [2:0]  w_data_q;   // control bits only
    logic        w_strb_q;
    logic        aw_hs;
    logic        w_hs;
    logic        wr_go;
    logic [3:0]  wr_addr_now;
    logic [2:0]  wr_data_now;
    logic        wr_strb_now;
    logic        ar_hs;

    assign awready = wr_state == WR_IDLE || wr_state == WR_DATA;
    assign wready  = wr_state == WR_IDLE || wr_state == WR_ADDR;
    assign bvalid  = wr_state == WR_RESP;
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;

    // pair the halves, whichever came first
    assign wr_addr_now = aw_hs ? awaddr : aw_addr_q;
    assign wr_data_now = w_hs ? wdata[2:0] : w_data_q;
    assign wr_strb_now = w_hs ? wstrb[0] : w_strb_q;
    assign wr_go = (aw_hs || wr_state == WR_ADDR) && (w_hs || wr_state == WR_DATA);

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
        end
        if (w_hs) begin
            w_data_q <= wdata[2:0];
            w_strb_q <= wstrb[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            bresp    <= RESP_OKAY;
            sl_mode  <= SL_PURE;
            blend_en <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_go) begin
                        wr_state <= WR_RESP;
                    end else if (aw_hs) begin
                        wr_state <= WR_ADDR;
                    end else if (w_hs) begin
                        wr_state <= WR_DATA;
                    end
                end
                WR_ADDR, WR_DATA: begin
                    if (wr_go) begin
                        wr_state <= WR_RESP;
                    end
                end
                default: begin
                    if (bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
            endcase
            if (wr_go) begin
                // line length is read only, a write there is accepted and dropped
                if (wr_addr_now == `SCAN2X_REG_CTRL || wr_addr_now == `SCAN2X_REG_LINELEN) begin
                    bresp <= RESP_OKAY;
                end else begin
                    bresp <= RESP_SLVERR;
                end
                if (wr_addr_now == `SCAN2X_REG_CTRL && wr_strb_now) begin
                    sl_mode  <= sl_mode_e'(wr_data_now[1:0]);
                    blend_en <= wr_data_now[2];
                end
            end
        end
    end

    assign arready = ~rvalid;
    assign ar_hs   = arvalid & arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
        end else if (ar_hs) begin
            rvalid <= 1'b1;
            if (araddr == `SCAN2X_REG_CTRL || araddr == `SCAN2X_REG_LINELEN) begin
                rresp <= RESP_OKAY;
            end else begin
                rresp <= RESP_SLVERR;
            end
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            case (araddr)
                `SCAN2X_REG_CTRL:    rdata <= {29'd0, blend_en, sl_mode};
                `SCAN2X_REG_LINELEN: rdata <= {{(32-`SCAN2X_AW){1'b0}}, line_len};
                default:             rdata <= '0;
            endcase
        end
    end

    // a response is held until the master takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: verilog/scan2x_line_timing.sv
// line timing with sync edges, write and read counters, ping-pong select, output sync and line length
`timescale 1ns/1ps
`include "scan2x_config.svh"

module scan2x_line_timing (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    input  logic                    pxl2_cen,
    input  logic                    hs,
    output logic                    wr_en,
    output logic                    line_sel,   // half being read while the other one fills
    output scan2x_pkg::line_addr_t  wr_addr,
    output scan2x_pkg::line_addr_t  rd_addr,
    output logic                    rd_first,
    output logic                    rd_step,
    output logic                    scanline_on,
    output logic                    de_early,
    output logic                    hs_early,
    output scan2x_pkg::line_addr_t  line_len
);
    import scan2x_pkg::*;

    logic                  hs_base_q;   // sync at the base rate
    logic                  hs_dbl_q;    // sync at the double rate
    logic                  base_fall;
    logic                  dbl_rise;
    logic                  started;
    logic                  wr_half;
    logic [`SCAN2X_AW:0]   dbl_cnt;     // double-rate steps since the last sync
    line_addr_t            rd_wrap;
    line_addr_t            rd_next;
    line_addr_t            len_next;
    logic                  hs_next;

    assign base_fall = pxl_cen & hs_base_q & ~hs;
    assign dbl_rise  = pxl2_cen & hs & ~hs_dbl_q;
    assign wr_en     = pxl_cen & started & ~hs;  // only active pixels are stored

    // write side, base rate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_base_q <= 1'b0;
            wr_addr   <= '0;
            wr_half   <= 1'b0;
        end else if (pxl_cen) begin
            hs_base_q <= hs;
            if (hs) begin
                wr_addr <= '0;
            end else if (started) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (base_fall) begin
                wr_half <= ~line_sel;  // half this line is going to fill
            end
        end
    end

    // restart the read on a new input line and wrap at half the input period
    always_comb begin
        len_next = dbl_rise ? wr_addr : line_len;
        if (dbl_rise || rd_addr == rd_wrap) begin
            rd_next = '0;
        end else begin
            rd_next = rd_addr + 1'b1;
        end
        hs_next = rd_next >= len_next;  // blanking after the active part
    end

    // read side, double rate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_dbl_q    <= 1'b0;
            started     <= 1'b0;
            line_sel    <= 1'b0;
            dbl_cnt     <= '0;
            rd_wrap     <= '0;
            line_len    <= '0;
            rd_addr     <= '0;
            rd_step     <= 1'b0;
            rd_first    <= 1'b0;
            de_early    <= 1'b0;
            hs_early    <= 1'b0;
            scanline_on <= 1'b0;
        end else begin
            rd_step <= pxl2_cen & (started | dbl_rise);
            if (pxl2_cen) begin
                hs_dbl_q <= hs;
                if (dbl_rise) begin
                    started  <= 1'b1;
                    line_sel <= ~line_sel;
                    line_len <= wr_addr;
                    rd_wrap  <= dbl_cnt[`SCAN2X_AW:1];  // two output lines per input line
                    dbl_cnt  <= '0;
                end else begin
                    dbl_cnt <= dbl_cnt + 1'b1;
                end
                if (started || dbl_rise) begin
                    rd_addr  <= rd_next;
                    rd_first <= rd_next == '0;
                    de_early <= rd_next < len_next;
                    hs_early <= hs_next;
                    if (dbl_rise) begin
                        scanline_on <= 1'b0;  // first copy is the normal line
                    end else if (hs_next && !hs_early) begin
                        scanline_on <= ~scanline_on;
                    end
                end
            end
        end
    end

    // read side must not move onto the half being filled during a line
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && !base_fall |-> wr_half != line_sel);

    // the active part ends before the read wraps for the second copy
    assert property (@(posedge clk) disable iff (!rst_n)
        de_early |-> rd_addr != rd_wrap);

endmodule

// File: verilog/line_buffer_ram.sv
// two-line pixel buffer, one write port and one registered read port
`timescale 1ns/1ps
`include "scan2x_config.svh"

module line_buffer_ram (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`SCAN2X_AW:0]   wr_addr,  // msb picks the buffer half
    input  scan2x_pkg::pixel_t    wr_data,
    input  logic [`SCAN2X_AW:0]   rd_addr,
    output scan2x_pkg::pixel_t    rd_data
);
    import scan2x_pkg::*;

    pixel_t mem [0:(2**(`SCAN2X_AW+1))-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // data one clock after the address
    end

endmodule

// File: verilog/scan2x_pkg.sv
// scan doubler types: colour channel, RGB pixel, line address, scanline mode
`include "scan2x_config.svh"

package scan2x_pkg;

    typedef logic [`SCAN2X_COLORW-1:0] chan_t;

    // red in the top bits, blue at the bottom
    typedef logic [3*`SCAN2X_COLORW-1:0] pixel_t;

    typedef logic [`SCAN2X_AW-1:0] line_addr_t;

    typedef enum logic [1:0] {
        SL_PURE    = 2'd0,  // scanline shown as is
        SL_HALF    = 2'd1,
        SL_QUARTER = 2'd2,
        SL_BLACK   = 2'd3
    } sl_mode_e;

endpackage

// File: verilog/scan2x_config.svh
// build constants for the scan doubler: colour depth, line address width, register offsets
`ifndef SCAN2X_CONFIG_SVH
`define SCAN2X_CONFIG_SVH

// bits per colour channel
`define SCAN2X_COLORW 4

// address bits within one line, up to 512 pixels
`define SCAN2X_AW 9

// AXI4-Lite byte offsets
`define SCAN2X_REG_CTRL    4'h0
`define SCAN2X_REG_LINELEN 4'h4

`endif
